// ==== collision.sv ====
`timescale 1ns/1ps

module collision import mmio_pkg::*; (
	input  coord_u       stage_pos,
	input  coord_u       stage_size,
	copro_if.coll_unit   bus
);

	logic [16:0] px, py, pw, ph;  // Player, one spare bit so edges never wrap
	logic [16:0] sx, sy, sw, sh;  // Stage
	logic [16:0] p_right, p_bot;
	logic [16:0] s_right, s_bot;
	logic        overlap;

	assign px = {1'b0, bus.position.xy.x};  // Halves taken as unsigned
	assign py = {1'b0, bus.position.xy.y};
	assign pw = {1'b0, bus.player_size.xy.x};
	assign ph = {1'b0, bus.player_size.xy.y};
	assign sx = {1'b0, stage_pos.xy.x};
	assign sy = {1'b0, stage_pos.xy.y};
	assign sw = {1'b0, stage_size.xy.x};
	assign sh = {1'b0, stage_size.xy.y};

	assign p_right = px + pw;
	assign p_bot   = py + ph;
	assign s_right = sx + sw;
	assign s_bot   = sy + sh;

	assign overlap = (px < s_right) && (sx < p_right) && (py < s_bot) && (sy < p_bot);

	assign bus.coll[coll_left]   = overlap && (px < sx);
	assign bus.coll[coll_right]  = overlap && (p_right > s_right);
	assign bus.coll[coll_top]    = overlap && (p_bot > s_bot);
	assign bus.coll[coll_bottom] = overlap && (py < sy);

	always_comb begin
		if (!overlap)
			assert (bus.coll == 4'b0000) else $error("side bit set without overlap");
	end

endmodule

// ==== copro_if.sv ====
`timescale 1ns/1ps

interface copro_if import mmio_pkg::*; ();

	coord_u     gravity;       // Per-frame acceleration, y half used
	coord_u     wind;          // Per-frame drift, x half used
	coord_u     start;         // Spawn position
	coord_u     knock;         // One-shot impulse
	logic       start_load;    // Pulse after a start write
	logic       knock_load;    // Pulse after a knock write
	coord_u     player_size;   // Width and height
	coord_u     position;      // Current top-left corner
	logic [3:0] coll;          // Side bits against the stage

	modport regs (
		output gravity, wind, start, knock, start_load, knock_load, player_size,
		input  position, coll
	);

	modport phys (
		input  gravity, wind, start, knock, start_load, knock_load, coll,
		output position
	);

	modport coll_unit (
		input  position, player_size,
		output coll
	);

endinterface

// ==== copro_regs.sv ====
`timescale 1ns/1ps

module copro_regs import mmio_pkg::*; (
	input  logic         clock,
	input  logic         rst_n,
	input  logic [12:0]  address,
	input  logic [31:0]  data_in,
	input  logic         wren,
	input  logic [15:0]  ctrl_p1,
	input  logic [15:0]  ctrl_p2,
	copro_if.regs        p1,
	copro_if.regs        p2,
	output coord_u       stage_pos,
	output coord_u       stage_size,
	output logic [31:0]  rd_data     // Readback, one cycle late
);

	logic [4:0]  blk;       // Address bits 11:7
	logic [4:0]  rsel;      // Address bits 6:2
	logic        cop_wr;    // Write into coprocessor space
	logic        wr_phys1;
	logic        wr_phys2;
	logic        wr_stage;
	logic [31:0] rd_next;

	assign blk      = address[11:7];
	assign rsel     = address[6:2];
	assign cop_wr   = wren && address[12];
	assign wr_phys1 = cop_wr && (blk == blk_phys_p1);
	assign wr_phys2 = cop_wr && (blk == blk_phys_p2);
	assign wr_stage = cop_wr && (blk == blk_stage);

	// Player 1 parameters and strobes
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			p1.gravity.raw     <= rst_gravity;
			p1.wind.raw        <= rst_wind;
			p1.start.raw       <= rst_start_p1;
			p1.knock.raw       <= '0;
			p1.player_size.raw <= rst_player_size;
			p1.start_load      <= 1'b0;
			p1.knock_load      <= 1'b0;
		end else begin
			p1.start_load <= wr_phys1 && (rsel == reg_start);  // Lands with the new value
			p1.knock_load <= wr_phys1 && (rsel == reg_knock);
			if (wr_phys1) begin
				case (rsel)
					reg_gravity: p1.gravity.raw <= data_in;
					reg_wind:    p1.wind.raw    <= data_in;
					reg_start:   p1.start.raw   <= data_in;
					reg_knock:   p1.knock.raw   <= data_in;
					default:     ;               // Unmapped, dropped
				endcase
			end
			if (cop_wr && blk == blk_coll_p1 && rsel == reg_size)
				p1.player_size.raw <= data_in;
		end
	end

	// Player 2, same map one block up
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			p2.gravity.raw     <= rst_gravity;
			p2.wind.raw        <= rst_wind;
			p2.start.raw       <= rst_start_p2;
			p2.knock.raw       <= '0;
			p2.player_size.raw <= rst_player_size;
			p2.start_load      <= 1'b0;
			p2.knock_load      <= 1'b0;
		end else begin
			p2.start_load <= wr_phys2 && (rsel == reg_start);
			p2.knock_load <= wr_phys2 && (rsel == reg_knock);
			if (wr_phys2) begin
				case (rsel)
					reg_gravity: p2.gravity.raw <= data_in;
					reg_wind:    p2.wind.raw    <= data_in;
					reg_start:   p2.start.raw   <= data_in;
					reg_knock:   p2.knock.raw   <= data_in;
					default:     ;
				endcase
			end
			if (cop_wr && blk == blk_coll_p2 && rsel == reg_size)
				p2.player_size.raw <= data_in;
		end
	end

	// Shared stage rectangle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			stage_pos.raw  <= rst_stage_pos;
			stage_size.raw <= rst_stage_size;
		end else if (wr_stage) begin
			if (rsel == reg_stage_pos)
				stage_pos.raw <= data_in;
			if (rsel == reg_stage_size)
				stage_size.raw <= data_in;
		end
	end

	// Read map, stage reads pass a same-cycle write straight through
	always_comb begin
		case (blk)
			blk_phys_p1: rd_next = p1.position.raw;  // Any register
			blk_phys_p2: rd_next = p2.position.raw;
			blk_ctrl_p1: rd_next = {16'h0000, ctrl_p1};
			blk_ctrl_p2: rd_next = {16'h0000, ctrl_p2};
			blk_coll_p1: rd_next = {28'h0, p1.coll};
			blk_coll_p2: rd_next = {28'h0, p2.coll};
			blk_stage: begin
				if (rsel == reg_stage_pos)
					rd_next = wr_stage ? data_in : stage_pos.raw;
				else if (rsel == reg_stage_size)
					rd_next = wr_stage ? data_in : stage_size.raw;
				else
					rd_next = '0;
			end
			default:     rd_next = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			rd_data <= '0;
		else
			rd_data <= rd_next;
	end

	// One bus write pulses at most one load strobe in either player
	a_one_strobe: assert property (
		@(posedge clock) disable iff (!rst_n)
		$onehot0({p1.start_load, p1.knock_load, p2.start_load, p2.knock_load})
	) else $error("two load strobes from one write");

endmodule

// ==== dmem.sv ====
`timescale 1ns/1ps

module dmem (
	input  logic        clock,
	input  logic [11:0] address,  // Word address
	input  logic [31:0] data,
	input  logic        wren,
	output logic [31:0] q         // Valid the cycle after the address
);

	logic [31:0] mem [0:4095];

	always_ff @(posedge clock) begin
		if (wren) begin
			mem[address] <= data;
			q            <= data;  // Write-first on the same address
		end else begin
			q <= mem[address];
		end
	end

	// An unknown write address would smear data across the array
	a_addr_known: assert property (
		@(posedge clock) wren |-> !$isunknown(address)
	) else $error("dmem write with unknown address");

endmodule

// ==== mmio.sv ====
`timescale 1ns/1ps

module mmio import mmio_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic [12:0] address,    // Word address, bit 12 picks coprocessors
	input  logic [31:0] data_in,
	input  logic        wren,
	output logic [31:0] data_out,
	input  logic        frame,      // Physics tick
	input  logic [15:0] ctrl_p1,
	input  logic [15:0] ctrl_p2,
	output logic [63:0] p1_vga,     // Position, then size
	output logic [63:0] p2_vga,
	output logic [63:0] stage_vga
);

	copro_if     p1_bus ();
	copro_if     p2_bus ();
	coord_u      stage_pos;
	coord_u      stage_size;
	logic [31:0] q_dmem;
	logic [31:0] rd_copro;
	logic        rd_sel_copro;  // Bit 12 of last cycle's address

	dmem mem (
		.clock   (clock),
		.address (address[11:0]),
		.data    (data_in),
		.wren    (wren && !address[12]),  // Low half of the map only
		.q       (q_dmem)
	);

	copro_regs regs (
		.clock      (clock),
		.rst_n      (rst_n),
		.address    (address),
		.data_in    (data_in),
		.wren       (wren),
		.ctrl_p1    (ctrl_p1),
		.ctrl_p2    (ctrl_p2),
		.p1         (p1_bus.regs),
		.p2         (p2_bus.regs),
		.stage_pos  (stage_pos),
		.stage_size (stage_size),
		.rd_data    (rd_copro)
	);

	physics_coprocessor #(.rst_pos(rst_start_p1)) phys_p1 (
		.clock (clock),
		.rst_n (rst_n),
		.frame (frame),
		.ctrl  (ctrl_p1),
		.bus   (p1_bus.phys)
	);

	physics_coprocessor #(.rst_pos(rst_start_p2)) phys_p2 (
		.clock (clock),
		.rst_n (rst_n),
		.frame (frame),
		.ctrl  (ctrl_p2),
		.bus   (p2_bus.phys)
	);

	collision coll_p1 (
		.stage_pos  (stage_pos),
		.stage_size (stage_size),
		.bus        (p1_bus.coll_unit)
	);

	collision coll_p2 (
		.stage_pos  (stage_pos),
		.stage_size (stage_size),
		.bus        (p2_bus.coll_unit)
	);

	// Resets to the register side so data_out starts at zero, not at stale RAM
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			rd_sel_copro <= 1'b1;
		else
			rd_sel_copro <= address[12];
	end

	assign data_out  = rd_sel_copro ? rd_copro : q_dmem;
	assign p1_vga    = {p1_bus.position.raw, p1_bus.player_size.raw};
	assign p2_vga    = {p2_bus.position.raw, p2_bus.player_size.raw};
	assign stage_vga = {stage_pos.raw, stage_size.raw};

endmodule

// ==== mmio_checker.sv ====
`timescale 1ns/1ps

module mmio_checker import mmio_pkg::*; (
	input logic        clock,
	input logic        rst_n,
	input logic [12:0] address,
	input logic [31:0] data_in,
	input logic        wren,
	input logic [31:0] data_out,
	input logic        frame,
	input logic [15:0] ctrl_p1,
	input logic [15:0] ctrl_p2,
	input logic [63:0] p1_vga,
	input logic [63:0] p2_vga,
	input logic [63:0] stage_vga
);

	int          errors;                  // Read by the testbench top
	int          compares;
	logic [31:0] mem_m [0:4095];          // Model of dmem contents
	coord_u      grav [2];
	coord_u      wind [2];
	coord_u      start [2];
	coord_u      knock [2];
	coord_u      size [2];
	coord_u      pos [2];
	coord_u      pend [2];                // Impulse waiting for a frame
	logic [1:0]  sload;                   // Strobes one cycle after the write
	logic [1:0]  kload;
	coord_u      spos;
	coord_u      ssize;
	logic [3:0]  cm [2];                  // Expected coll this cycle
	logic [31:0] rd_exp;
	logic        rd_due;                  // data_out check pending
	logic        cop_wr;
	logic [4:0]  blk;
	logic [4:0]  rsel;
	logic [4:0]  pblk;

	// Overlap on unsigned halves, bits bottom top right left
	function automatic logic [3:0] collide(coord_u p, coord_u s, coord_u sp, coord_u ss);
		logic [16:0] px, py, pr, pb;
		logic [16:0] sx, sy, sr, sb;
		logic        hit;
		px = {1'b0, p.xy.x};
		py = {1'b0, p.xy.y};
		pr = px + {1'b0, s.xy.x};
		pb = py + {1'b0, s.xy.y};
		sx = {1'b0, sp.xy.x};
		sy = {1'b0, sp.xy.y};
		sr = sx + {1'b0, ss.xy.x};
		sb = sy + {1'b0, ss.xy.y};
		hit = (px < sr) && (sx < pr) && (py < sb) && (sy < pb);
		return {hit && (py < sy), hit && (pb > sb), hit && (pr > sr), hit && (px < sx)};
	endfunction

	// One frame of motion with side blocking
	function automatic coord_u advance(coord_u p, coord_u g, coord_u w, coord_u k,
			logic [15:0] btn, logic [3:0] c);
		logic signed [15:0] dx;
		logic signed [15:0] dy;
		coord_u             n;
		dx = w.xy.x + k.xy.x;
		dy = g.xy.y + k.xy.y;
		if (btn[btn_right] && !btn[btn_left])
			dx = dx + move_step[15:0];
		if (btn[btn_left] && !btn[btn_right])
			dx = dx - move_step[15:0];
		if ((dy > 0 && c[coll_bottom]) || (dy < 0 && c[coll_top]))
			dy = '0;
		if ((dx > 0 && c[coll_left]) || (dx < 0 && c[coll_right]))
			dx = '0;
		n.xy.x = p.xy.x + dx;                // 16-bit wrap
		n.xy.y = p.xy.y + dy;
		return n;
	endfunction

	// Expected read data for a word address
	function automatic logic [31:0] read_map(logic [12:0] a);
		if (!a[12])
			return mem_m[a[11:0]];
		case (a[11:7])
			blk_phys_p1: return pos[0].raw;
			blk_phys_p2: return pos[1].raw;
			blk_ctrl_p1: return {16'h0, ctrl_p1};
			blk_ctrl_p2: return {16'h0, ctrl_p2};
			blk_coll_p1: return {28'h0, cm[0]};
			blk_coll_p2: return {28'h0, cm[1]};
			blk_stage: begin
				if (a[6:2] == reg_stage_pos)
					return spos.raw;
				if (a[6:2] == reg_stage_size)
					return ssize.raw;
				return 32'h0;
			end
			default: return 32'h0;
		endcase
	endfunction

	task automatic compare(string name, logic [63:0] exp, logic [63:0] got);
		compares++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	initial begin
		errors   = 0;
		compares = 0;
	end

	// Model update from the bus sampled at each edge
	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2; i++) begin
				grav[i].raw  = rst_gravity;
				wind[i].raw  = rst_wind;
				knock[i].raw = '0;
				size[i].raw  = rst_player_size;
				pend[i].raw  = '0;
			end
			start[0].raw = rst_start_p1;
			start[1].raw = rst_start_p2;
			pos[0].raw   = rst_start_p1;
			pos[1].raw   = rst_start_p2;
			sload        = '0;
			kload        = '0;
			spos.raw     = rst_stage_pos;
			ssize.raw    = rst_stage_size;
			rd_due       = 1'b0;
		end else begin
			cm[0]  = collide(pos[0], size[0], spos, ssize);
			cm[1]  = collide(pos[1], size[1], spos, ssize);
			rd_due = !wren;
			rd_exp = read_map(address);          // State before this edge
			cop_wr = wren && address[12];
			blk    = address[11:7];
			rsel   = address[6:2];
			if (wren && !address[12])
				mem_m[address[11:0]] = data_in;
			for (int i = 0; i < 2; i++) begin
				if (sload[i])
					pos[i] = start[i];           // Respawn wins over the frame
				else if (frame)
					pos[i] = advance(pos[i], grav[i], wind[i], pend[i],
						i ? ctrl_p2 : ctrl_p1, cm[i]);
				if (kload[i])
					pend[i] = knock[i];
				else if (frame && !sload[i])
					pend[i].raw = '0;
				pblk     = i ? blk_phys_p2 : blk_phys_p1;
				sload[i] = cop_wr && blk == pblk && rsel == reg_start;
				kload[i] = cop_wr && blk == pblk && rsel == reg_knock;
				if (cop_wr && blk == pblk && rsel == reg_gravity)
					grav[i].raw = data_in;
				if (cop_wr && blk == pblk && rsel == reg_wind)
					wind[i].raw = data_in;
				if (sload[i])
					start[i].raw = data_in;
				if (kload[i])
					knock[i].raw = data_in;
				if (cop_wr && blk == (i ? blk_coll_p2 : blk_coll_p1) && rsel == reg_size)
					size[i].raw = data_in;
			end
			if (cop_wr && blk == blk_stage && rsel == reg_stage_pos)
				spos.raw = data_in;
			if (cop_wr && blk == blk_stage && rsel == reg_stage_size)
				ssize.raw = data_in;
		end
	end

	// Outputs are settled at the falling edge
	always @(negedge clock) begin
		if (rst_n) begin
			compare("p1_vga", {pos[0].raw, size[0].raw}, p1_vga);
			compare("p2_vga", {pos[1].raw, size[1].raw}, p2_vga);
			compare("stage_vga", {spos.raw, ssize.raw}, stage_vga);
			if (rd_due)
				compare("data_out", {32'h0, rd_exp}, {32'h0, data_out});
		end
	end

endmodule

// ==== mmio_pkg.sv ====
package mmio_pkg;

	// One 32-bit coordinate word, raw from the bus or split into x and y
	typedef union packed {
		logic [31:0] raw;                 // As written by the processor
		struct packed {
			logic signed [15:0] x;        // Upper half
			logic signed [15:0] y;        // Lower half
		} xy;
	} coord_u;

	// Block field, address bits 11:7
	localparam logic [4:0] blk_phys_p1 = 5'd0;
	localparam logic [4:0] blk_phys_p2 = 5'd1;
	localparam logic [4:0] blk_ctrl_p1 = 5'd4;
	localparam logic [4:0] blk_ctrl_p2 = 5'd5;
	localparam logic [4:0] blk_stage   = 5'd10;
	localparam logic [4:0] blk_coll_p1 = 5'd12;
	localparam logic [4:0] blk_coll_p2 = 5'd13;

	// Register field, address bits 6:2
	localparam logic [4:0] reg_gravity    = 5'd0;  // Physics blocks
	localparam logic [4:0] reg_wind       = 5'd1;
	localparam logic [4:0] reg_start      = 5'd2;
	localparam logic [4:0] reg_knock      = 5'd3;
	localparam logic [4:0] reg_size       = 5'd0;  // Collision blocks
	localparam logic [4:0] reg_stage_pos  = 5'd0;  // Stage block
	localparam logic [4:0] reg_stage_size = 5'd1;

	// Horizontal step per frame while a direction is held
	localparam logic [31:0] move_step = 32'd4;

	// Power-up values
	localparam logic [31:0] rst_gravity     = 32'h0001_0000;
	localparam logic [31:0] rst_wind        = 32'h0000_0000;
	localparam logic [31:0] rst_start_p1    = 32'h0160_00fa;  // x 352, y 250
	localparam logic [31:0] rst_start_p2    = 32'h01a9_00fa;  // x 425, y 250
	localparam logic [31:0] rst_player_size = 32'h0085_007d;
	localparam logic [31:0] rst_stage_pos   = 32'h0143_0014;
	localparam logic [31:0] rst_stage_size  = 32'h01fa_00c8;

	// Controller word bits
	localparam int btn_left  = 0;
	localparam int btn_right = 1;

	// Collision side bits
	localparam int coll_left   = 0;
	localparam int coll_right  = 1;
	localparam int coll_top    = 2;
	localparam int coll_bottom = 3;

endpackage

// ==== physics_coprocessor.sv ====
`timescale 1ns/1ps

module physics_coprocessor import mmio_pkg::*; #(
	parameter logic [31:0] rst_pos = rst_start_p1  // Spawn point after reset
) (
	input  logic         clock,
	input  logic         rst_n,
	input  logic         frame,  // One step per pulse
	input  logic [15:0]  ctrl,   // Button levels
	copro_if.phys        bus
);

	coord_u             pend;      // Knockback waiting for the next frame
	coord_u             pos_next;  // Position after this frame's motion
	logic signed [15:0] dx_raw;
	logic signed [15:0] dy_raw;
	logic signed [15:0] dx;        // After collision blocking
	logic signed [15:0] dy;

	always_comb begin
		dx_raw = bus.wind.xy.x + pend.xy.x;
		if (ctrl[btn_right])
			dx_raw = dx_raw + move_step[15:0];
		if (ctrl[btn_left])
			dx_raw = dx_raw - move_step[15:0];  // Both held cancels out
		dy_raw = bus.gravity.xy.y + pend.xy.y;

		dx = dx_raw;
		dy = dy_raw;
		if (dy_raw > 0 && bus.coll[coll_bottom])
			dy = '0;                 // Standing on something
		if (dy_raw < 0 && bus.coll[coll_top])
			dy = '0;
		if (dx_raw > 0 && bus.coll[coll_left])
			dx = '0;
		if (dx_raw < 0 && bus.coll[coll_right])
			dx = '0;

		pos_next.xy.x = bus.position.xy.x + dx;  // Wraps at 16 bits
		pos_next.xy.y = bus.position.xy.y + dy;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			bus.position.raw <= rst_pos;
		end else if (bus.start_load) begin
			bus.position <= bus.start;      // Respawn beats the frame step
		end else if (frame) begin
			bus.position <= pos_next;
		end
	end

	// Impulse is consumed only by a frame that actually moved the player
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pend.raw <= '0;
		end else if (bus.knock_load) begin
			pend <= bus.knock;              // Fresh impulse held for the next frame
		end else if (frame && !bus.start_load) begin
			pend.raw <= '0;                 // Applied once
		end
	end

	// Position only moves on a frame or a respawn
	a_pos_hold: assert property (
		@(posedge clock) disable iff (!rst_n)
		!frame && !bus.start_load |=> $stable(bus.position.raw)
	) else $error("position moved without frame or start_load");

endmodule

// ==== project.f ====
mmio_pkg.sv
copro_if.sv
physics_coprocessor.sv
collision.sv
dmem.sv
copro_regs.sv
mmio.sv
mmio_checker.sv
tb_mmio.sv

// ==== tb_mmio.sv ====
`timescale 1ns/1ps

module tb_mmio import mmio_pkg::*; ();

	localparam logic [12:0] idle_addr = 13'h1fff;  // Unmapped address reading 0
	localparam int n_mem     = 16;
	localparam int n_frames  = 12;
	localparam int run_cycles = 16 + (2 * n_mem + 8) + 14 + (n_frames * 10 + 6)
		+ (4 * 13 + 8) + 24;
	localparam int watchdog_cycles = run_cycles + 1000;

	logic        clock;
	logic        rst_n;
	logic [12:0] address;
	logic [31:0] data_in;
	logic        wren;
	logic [31:0] data_out;
	logic        frame;
	logic [15:0] ctrl_p1;
	logic [15:0] ctrl_p2;
	logic [63:0] p1_vga;
	logic [63:0] p2_vga;
	logic [63:0] stage_vga;
	logic [31:0] seed = 32'hd2e2_0500;
	logic [12:0] mem_addr [n_mem];
	int          base_err;
	int          tests_bad;

	mmio i_mmio (.*);
	mmio_checker mon (.*);                           // Compares every port

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function logic [31:0] rand32();
		seed = xorshift32(seed);
		return seed;
	endfunction

	function automatic logic [12:0] cop(logic [4:0] blk, logic [4:0] rsel);
		return {1'b1, blk, rsel, 2'b00};
	endfunction

	// Both halves between -4 and 3
	function automatic logic [31:0] small_pair(logic [31:0] r);
		return {{13{r[18]}}, r[18:16], {13{r[2]}}, r[2:0]};
	endfunction

	task automatic drive(logic [12:0] a, logic [31:0] d, logic we, logic fr);
		@(posedge clock);
		address <= a;
		data_in <= d;
		wren    <= we;
		frame   <= fr;
	endtask

	task automatic bus_write(logic [12:0] a, logic [31:0] d);
		drive(a, d, 1'b1, 1'b0);
	endtask

	task automatic bus_read(logic [12:0] a);
		drive(a, 32'h0, 1'b0, 1'b0);
	endtask

	task automatic frame_tick();
		drive(idle_addr, 32'h0, 1'b0, 1'b1);
	endtask

	task automatic idle(int n);
		repeat (n) drive(idle_addr, 32'h0, 1'b0, 1'b0);
	endtask

	task automatic set_ctrl(logic [15:0] c1, logic [15:0] c2);
		drive(idle_addr, 32'h0, 1'b0, 1'b0);
		ctrl_p1 <= c1;
		ctrl_p2 <= c2;
	endtask

	// Same values into both players
	task automatic write_both(logic [4:0] rsel, logic [31:0] d);
		bus_write(cop(blk_phys_p1, rsel), d);
		bus_write(cop(blk_phys_p2, rsel), d);
	endtask

	task automatic report_test(string name);
		int n;
		idle(2);                                     // Last read reaches data_out
		n = mon.errors - base_err;
		$display("Test %s: %s, %0d mismatches", name, n == 0 ? "ok" : "bad", n);
		if (n != 0)
			tests_bad++;
		base_err = mon.errors;
	endtask

	initial begin
		logic [31:0] r;
		logic [12:0] t;
		int          j;
		logic [31:0] spots [4];
		logic [31:0] push [4];
		rst_n     = 1'b0;
		address   = idle_addr;
		data_in   = '0;
		wren      = 1'b0;
		frame     = 1'b0;
		ctrl_p1   = '0;
		ctrl_p2   = '0;
		base_err  = 0;
		tests_bad = 0;
		spots     = '{32'h0050_0096, 32'h0118_0096, 32'h0096_0118, 32'h0096_0050};
		push      = '{32'h0003_0000, 32'hfffd_0000, 32'h0000_fffe, 32'h0000_0002};
		repeat (16) @(posedge clock);
		rst_n <= 1'b1;

		for (int i = 0; i < n_mem; i++) begin
			r = rand32();
			mem_addr[i] = {1'b0, r[11:0]};
			bus_write(mem_addr[i], rand32());
		end
		for (int i = n_mem - 1; i > 0; i--) begin    // Fisher-Yates
			r = rand32();
			j = r % (i + 1);
			t = mem_addr[i];
			mem_addr[i] = mem_addr[j];
			mem_addr[j] = t;
		end
		foreach (mem_addr[i])
			bus_read(mem_addr[i]);
		bus_read(cop(5'd2, 5'd0));
		bus_read(cop(5'd20, 5'd7));
		bus_read(cop(blk_stage, 5'd5));
		bus_read(cop(5'd31, 5'd31));
		report_test("1 dmem");

		bus_read(cop(blk_phys_p1, reg_gravity));
		bus_read(cop(blk_phys_p2, reg_knock));
		bus_read(cop(blk_stage, reg_stage_pos));
		bus_read(cop(blk_stage, reg_stage_size));
		bus_read(cop(blk_coll_p1, 5'd0));
		bus_read(cop(blk_coll_p2, 5'd0));
		bus_write(cop(blk_phys_p1, reg_start), 32'h0100_0080);
		bus_write(cop(blk_phys_p2, reg_start), 32'h0200_0090);
		idle(1);
		bus_read(cop(blk_phys_p1, reg_start));
		bus_read(cop(blk_phys_p2, reg_start));
		report_test("2 reset");

		bus_write(cop(blk_stage, reg_stage_pos), 32'h8000_8000);  // Far from both players
		bus_write(cop(blk_stage, reg_stage_size), 32'h0010_0010);
		for (int f = 0; f < n_frames; f++) begin
			bus_write(cop(blk_phys_p1, reg_gravity), small_pair(rand32()));
			bus_write(cop(blk_phys_p1, reg_wind), small_pair(rand32()));
			bus_write(cop(blk_phys_p2, reg_gravity), small_pair(rand32()));
			bus_write(cop(blk_phys_p2, reg_wind), small_pair(rand32()));
			r = rand32();
			set_ctrl(r[15:0], r[31:16]);
			frame_tick();
			bus_read(cop(blk_ctrl_p1, 5'd0));
			bus_read(cop(blk_ctrl_p2, 5'd3));
			bus_read(cop(blk_phys_p1, 5'd0));
			bus_read(cop(blk_phys_p2, 5'd0));
		end
		report_test("3 motion");

		set_ctrl(16'h0, 16'h0);
		bus_write(cop(blk_stage, reg_stage_pos), 32'h0064_0064);  // Stage 100..300
		bus_write(cop(blk_stage, reg_stage_size), 32'h00c8_00c8);
		bus_write(cop(blk_coll_p1, reg_size), 32'h0032_0032);
		bus_write(cop(blk_coll_p2, reg_size), 32'h0032_0032);
		for (int s = 0; s < 4; s++) begin            // Left, right, top, bottom
			write_both(reg_start, spots[s]);
			write_both(reg_gravity, push[s]);        // Push into the touching side
			write_both(reg_wind, push[s]);
			idle(1);
			bus_read(cop(blk_coll_p1, 5'd0));
			bus_read(cop(blk_coll_p2, 5'd0));
			frame_tick();
			frame_tick();
			bus_read(cop(blk_phys_p1, 5'd0));
			bus_read(cop(blk_phys_p2, 5'd0));
		end
		report_test("4 collision");

		bus_write(cop(blk_stage, reg_stage_pos), 32'h8000_8000);
		write_both(reg_gravity, 32'h0);
		write_both(reg_wind, 32'h0);
		write_both(reg_start, 32'h0100_0100);
		bus_write(cop(blk_phys_p1, reg_knock), 32'h000a_fffb);   // x +10, y -5
		idle(1);
		frame_tick();
		frame_tick();                                // Impulse already spent
		bus_read(cop(blk_phys_p1, 5'd0));
		write_both(reg_wind, 32'h0003_0000);         // Drift that a respawn must override
		bus_write(cop(blk_phys_p1, reg_start), 32'h0040_0040);
		frame_tick();                                // Strobe lands with this frame
		drive(cop(blk_phys_p2, reg_start), 32'h0050_0050, 1'b1, 1'b1);
		frame_tick();
		bus_read(cop(blk_phys_p1, 5'd0));
		bus_read(cop(blk_phys_p2, 5'd0));
		report_test("5 knock");

		$display("Summary: 5 tests, %0d bad, %0d compares, %0d mismatches",
			tests_bad, mon.compares, mon.errors);
		if (mon.errors == 0 && tests_bad == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		#(watchdog_cycles * 100);
		$display("Timeout: test sequence still running after %0d cycles", watchdog_cycles);
		$display("Errors found");
		$finish;
	end

endmodule
